/* src/scope_pkg.sv */
// scope trigger definitions
package scope_pkg;

   localparam int sample_w      = 12;
   localparam int lanes         = 4;
   localparam int lane_samples  = 10;
   localparam int frame_samples = lanes * lane_samples;
   localparam int addr_w        = 10;
   localparam int depth         = 1 << addr_w;
   localparam int len_w         = 16;

   typedef logic signed [sample_w-1:0] sample_t;

   // sample index is lane * lane_samples + position
   typedef sample_t [frame_samples-1:0] frame_t;

   typedef enum logic [7:0] {
      acq_idle,   // waiting for live and a trigger kind
      acq_pre,    // filling the pre-trigger part
      acq_armed,  // threshold, first step
      acq_fire,   // threshold, second step
      acq_lvds,   // waiting on a neighbour board
      acq_auto,   // forced capture
      acq_post,   // filling after the trigger
      acq_done    // held for host readout
   } acq_state_t;

   typedef enum logic [7:0] {
      trig_off  = 8'd0,
      trig_rise = 8'd1,
      trig_fall = 8'd2,
      trig_lvds = 8'd3,
      trig_auto = 8'd4
   } trig_kind_t;

   typedef struct packed {
      sample_t          lower_thresh;
      sample_t          upper_thresh;
      logic [len_w-1:0] pre_length;   // decimated frames before the trigger
      logic [len_w-1:0] post_length;  // decimated frames after the trigger
      trig_kind_t       trig_kind;
      logic             trig_chan;    // channel used in two-channel mode
      logic             dual_chan;
      logic [4:0]       downsample;   // log2 of the decimation step
      logic [7:0]       merging;      // extra step multiplier, 0 acts as 1
      logic             live;
   } cfg_t;

   typedef struct packed {
      logic [31:0]       event_count;
      logic [addr_w-1:0] trig_address;
      acq_state_t        state;
      logic              busy;
   } status_t;

endpackage

/* src/sample_decimator.sv */
// frame decimator and write strobe
`timescale 1ns/100ps

module sample_decimator (
   input  logic                          clklvds,
   input  logic                          rst_n,
   input  logic                          capture_en,
   input  logic [4:0]                    downsample,
   input  logic [7:0]                    merging,
   input  scope_pkg::frame_t             samples,
   output logic                          wr_strobe,
   output logic [scope_pkg::addr_w-1:0]  wr_addr,
   output scope_pkg::frame_t             wr_frame
);

   logic [31:0] ds_cnt;        // runs 1 .. 2^downsample
   logic [7:0]  merge_cnt;
   logic [4:0]  downsample_q;
   logic [7:0]  merging_q;
   logic        ds_last;
   logic        merge_last;
   logic        take;

   assign ds_last    = ds_cnt[downsample_q];
   assign merge_last = merge_cnt >= merging_q;  // merging of 0 or 1 ends at once
   assign take       = capture_en && ds_last && merge_last;

   always_ff @(posedge clklvds) begin
      if (!rst_n) begin
         downsample_q <= '0;
         merging_q    <= '0;
      end else begin
         downsample_q <= downsample;
         merging_q    <= merging;
      end
   end

   always_ff @(posedge clklvds) begin
      if (!rst_n || !capture_en) begin
         ds_cnt    <= 32'd1;  // reload while not capturing
         merge_cnt <= 8'd1;
      end else if (ds_last) begin
         ds_cnt    <= 32'd1;
         merge_cnt <= merge_last ? 8'd1 : merge_cnt + 8'd1;
      end else begin
         ds_cnt    <= ds_cnt + 32'd1;
      end
   end

   always_ff @(posedge clklvds) begin
      if (!rst_n) begin
         wr_strobe <= 1'b0;
         wr_addr   <= '0;
      end else begin
         wr_strobe <= take;
         if (take) wr_addr <= wr_addr + 1'b1;  // wraps over the ring
      end
   end

   always_ff @(posedge clklvds) begin
      if (take) wr_frame <= samples;  // frame seen on the deciding cycle
   end

   // a step above one leaves a gap after every store
   a_strobe_gap : assert property (@(posedge clklvds) disable iff (!rst_n)
      (wr_strobe && downsample_q != 5'd0) |=> !wr_strobe);

endmodule

/* src/edge_detector.sv */
// threshold crossing detector
`timescale 1ns/100ps

module edge_detector (
   input  logic               clklvds,
   input  logic               rst_n,
   input  scope_pkg::frame_t  samples,
   input  scope_pkg::sample_t lower_thresh,
   input  scope_pkg::sample_t upper_thresh,
   input  logic               trig_chan,
   input  logic               dual_chan,
   output logic               low_hit,
   output logic               high_hit
);

   scope_pkg::sample_t                  lower_q;
   scope_pkg::sample_t                  upper_q;
   logic                                trig_chan_q;
   logic                                dual_q;
   logic [scope_pkg::lanes-1:0]         lane_sel;
   logic [scope_pkg::frame_samples-1:0] below;
   logic [scope_pkg::frame_samples-1:0] above;

   always_ff @(posedge clklvds) begin
      if (!rst_n) begin
         lower_q     <= '0;
         upper_q     <= '0;
         trig_chan_q <= 1'b0;
         dual_q      <= 1'b0;
      end else begin
         lower_q     <= lower_thresh;
         upper_q     <= upper_thresh;
         trig_chan_q <= trig_chan;
         dual_q      <= dual_chan;
      end
   end

   // lanes 0 and 2 carry channel 0, lanes 1 and 3 carry channel 1
   for (genvar l = 0; l < scope_pkg::lanes; l++) begin : g_lane
      assign lane_sel[l] = !dual_q || (((l % 2) == 1) == trig_chan_q);
   end

   for (genvar i = 0; i < scope_pkg::frame_samples; i++) begin : g_cmp
      assign below[i] = lane_sel[i / scope_pkg::lane_samples]
                        && ($signed(samples[i]) < lower_q);
      assign above[i] = lane_sel[i / scope_pkg::lane_samples]
                        && ($signed(samples[i]) > upper_q);
   end

   always_ff @(posedge clklvds) begin
      if (!rst_n) begin
         low_hit  <= 1'b0;
         high_hit <= 1'b0;
      end else begin
         low_hit  <= |below;  // any selected sample under the lower level
         high_hit <= |above;
      end
   end

endmodule

/* src/wave_buffer.sv */
// decimated frame ring buffer
`timescale 1ns/100ps

module wave_buffer (
   input  logic                         clklvds,
   input  logic                         wr_strobe,
   input  logic [scope_pkg::addr_w-1:0] wr_addr,
   input  scope_pkg::frame_t            wr_frame,
   input  logic [scope_pkg::addr_w-1:0] rd_addr,
   output scope_pkg::frame_t            rd_data
);

   scope_pkg::frame_t mem [scope_pkg::depth];  // one frame per entry

   always_ff @(posedge clklvds) begin
      if (wr_strobe) mem[wr_addr] <= wr_frame;  // no stall, every strobe lands
   end

   // host read port, data one cycle after the address
   always_ff @(posedge clklvds) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* src/acq_fsm.sv */
// acquisition controller
`timescale 1ns/100ps

module acq_fsm (
   input  logic                         clklvds,
   input  logic                         rst_n,
   input  scope_pkg::cfg_t              cfg,
   input  logic                         wr_strobe,
   input  logic [scope_pkg::addr_w-1:0] wr_addr,
   input  logic                         low_hit,
   input  logic                         high_hit,
   input  logic                         lvds_trig_in,
   input  logic                         lvds_trig_in_b,
   input  logic                         readout_done,
   output logic                         capture_en,
   output logic                         lvds_trig_out,
   output logic                         lvds_trig_out_b,
   output scope_pkg::status_t           status
);

   scope_pkg::cfg_t                cfg_q;
   scope_pkg::acq_state_t          state;
   scope_pkg::trig_kind_t          active_kind;  // kind captured when leaving idle
   logic [scope_pkg::len_w-1:0]    strobe_cnt;
   logic [31:0]                    event_cnt;
   logic [scope_pkg::addr_w-1:0]   trig_addr;
   logic                           kind_changed;
   logic                           rising;
   logic                           arm_hit;
   logic                           fire;
   logic                           echo_b;

   assign kind_changed = cfg_q.trig_kind != active_kind;
   assign rising       = active_kind == scope_pkg::trig_rise;
   assign arm_hit      = rising ? low_hit : high_hit;
   assign capture_en   = (state != scope_pkg::acq_idle) && (state != scope_pkg::acq_done);

   always_comb begin
      fire   = 1'b0;
      echo_b = 1'b1;
      if (!kind_changed) begin
         case (state)
            scope_pkg::acq_fire: fire = rising ? high_hit : low_hit;
            scope_pkg::acq_lvds: begin
               fire   = lvds_trig_in || lvds_trig_in_b;
               echo_b = !lvds_trig_in;  // forward arrivals are not sent back
            end
            scope_pkg::acq_auto: fire = 1'b1;
            default: fire = 1'b0;
         endcase
      end
   end

   always_ff @(posedge clklvds) begin
      if (!rst_n) begin
         cfg_q <= '0;
      end else begin
         cfg_q <= cfg;
      end
   end

   always_ff @(posedge clklvds) begin
      if (!rst_n) begin
         state           <= scope_pkg::acq_idle;
         active_kind     <= scope_pkg::trig_off;
         strobe_cnt      <= '0;
         event_cnt       <= '0;
         lvds_trig_out   <= 1'b0;
         lvds_trig_out_b <= 1'b0;
      end else begin
         lvds_trig_out   <= fire;  // single cycle echo
         lvds_trig_out_b <= fire && echo_b;
         case (state)
            scope_pkg::acq_idle: begin
               active_kind <= cfg_q.trig_kind;
               strobe_cnt  <= '0;
               if (cfg_q.live && cfg_q.trig_kind != scope_pkg::trig_off)
                  state <= scope_pkg::acq_pre;
            end
            scope_pkg::acq_pre: begin
               if (kind_changed) begin
                  state <= scope_pkg::acq_idle;
               end else if (strobe_cnt < cfg_q.pre_length) begin
                  if (wr_strobe) strobe_cnt <= strobe_cnt + 1'b1;
               end else begin
                  strobe_cnt <= '0;  // reused for the post fill
                  case (active_kind)
                     scope_pkg::trig_rise: state <= scope_pkg::acq_armed;
                     scope_pkg::trig_fall: state <= scope_pkg::acq_armed;
                     scope_pkg::trig_lvds: state <= scope_pkg::acq_lvds;
                     scope_pkg::trig_auto: state <= scope_pkg::acq_auto;
                     default:              state <= scope_pkg::acq_idle;
                  endcase
               end
            end
            scope_pkg::acq_armed: begin
               if (kind_changed) state <= scope_pkg::acq_idle;
               else if (arm_hit) state <= scope_pkg::acq_fire;
            end
            scope_pkg::acq_fire, scope_pkg::acq_lvds, scope_pkg::acq_auto: begin
               if (kind_changed) state <= scope_pkg::acq_idle;
               else if (fire) state <= scope_pkg::acq_post;
            end
            scope_pkg::acq_post: begin
               if (strobe_cnt < cfg_q.post_length) begin
                  if (wr_strobe) strobe_cnt <= strobe_cnt + 1'b1;
               end else begin
                  event_cnt <= event_cnt + 32'd1;
                  state     <= scope_pkg::acq_done;
               end
            end
            scope_pkg::acq_done: begin
               if (readout_done) state <= scope_pkg::acq_idle;
            end
            default: state <= scope_pkg::acq_idle;
         endcase
      end
   end

   always_ff @(posedge clklvds) begin
      if (fire) trig_addr <= wr_addr;  // last frame stored before the trigger
   end

   assign status = '{event_count:  event_cnt,
                     trig_address: trig_addr,
                     state:        state,
                     busy:         capture_en};

   // neighbours see one pulse per event, never a level
   a_echo_one_cycle : assert property (@(posedge clklvds) disable iff (!rst_n)
      (lvds_trig_out || lvds_trig_out_b) |=> !(lvds_trig_out || lvds_trig_out_b));

endmodule

/* src/scope_trigger_top.sv */
// scope trigger top level
`timescale 1ns/100ps

module scope_trigger_top (
   input  logic                         clklvds,
   input  logic                         rst_n,
   input  scope_pkg::cfg_t              cfg,
   input  scope_pkg::frame_t            samples,
   input  logic                         readout_done,
   input  logic [scope_pkg::addr_w-1:0] rd_addr,
   input  logic                         lvds_trig_in,
   input  logic                         lvds_trig_in_b,
   output scope_pkg::status_t           status,
   output scope_pkg::frame_t            rd_data,
   output logic                         lvds_trig_out,
   output logic                         lvds_trig_out_b
);

   logic                         capture_en;
   logic                         wr_strobe;
   logic [scope_pkg::addr_w-1:0] wr_addr;
   scope_pkg::frame_t            wr_frame;
   logic                         low_hit;
   logic                         high_hit;

   sample_decimator u_decimator (
      .clklvds    (clklvds),
      .rst_n      (rst_n),
      .capture_en (capture_en),
      .downsample (cfg.downsample),
      .merging    (cfg.merging),
      .samples    (samples),
      .wr_strobe  (wr_strobe),
      .wr_addr    (wr_addr),
      .wr_frame   (wr_frame)
   );

   edge_detector u_detector (
      .clklvds      (clklvds),
      .rst_n        (rst_n),
      .samples      (samples),
      .lower_thresh (cfg.lower_thresh),
      .upper_thresh (cfg.upper_thresh),
      .trig_chan    (cfg.trig_chan),
      .dual_chan    (cfg.dual_chan),
      .low_hit      (low_hit),
      .high_hit     (high_hit)
   );

   wave_buffer u_buffer (
      .clklvds   (clklvds),
      .wr_strobe (wr_strobe),
      .wr_addr   (wr_addr),
      .wr_frame  (wr_frame),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   acq_fsm u_fsm (
      .clklvds         (clklvds),
      .rst_n           (rst_n),
      .cfg             (cfg),
      .wr_strobe       (wr_strobe),
      .wr_addr         (wr_addr),
      .low_hit         (low_hit),
      .high_hit        (high_hit),
      .lvds_trig_in    (lvds_trig_in),
      .lvds_trig_in_b  (lvds_trig_in_b),
      .readout_done    (readout_done),
      .capture_en      (capture_en),
      .lvds_trig_out   (lvds_trig_out),
      .lvds_trig_out_b (lvds_trig_out_b),
      .status          (status)
   );

endmodule

/* testbench/acq_monitor.sv */
// acquisition checker
`timescale 1ns/100ps

module acq_monitor (
   input  logic               clklvds,
   input  logic               rst_n,
   input  scope_pkg::cfg_t    cfg,
   input  scope_pkg::status_t status,
   input  logic               lvds_trig_in,
   input  logic               lvds_trig_out,
   input  logic               lvds_trig_out_b
);

   int                    mismatches = 0;
   int                    failures   = 0;
   int                    errors     = 0;
   int                    fwd_pulses = 0;
   int                    bwd_pulses = 0;
   int                    exp_events = 0;
   scope_pkg::acq_state_t prev_state = scope_pkg::acq_idle;
   logic                  prev_fwd_in = 1'b0;
   logic                  prev_out = 1'b0;

   // decimated period in input cycles, merging 0 counts as 1
   function automatic int expect_period(input logic [4:0] ds, input logic [7:0] m);
      int mult;
      mult = (m > 8'd1) ? int'(m) : 1;
      return (1 << ds) * mult;
   endfunction

   task automatic check_value(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
         mismatches++;
         errors++;
      end
   endtask

   task automatic fail(input string what);
      $display("ERROR at %0t: %s", $time, what);
      failures++;
      errors++;
   endtask

   // neighbouring stored frames are one period apart
   task automatic check_spacing(input string name, input logic [11:0] earlier,
                                input logic [11:0] later);
      logic [11:0] step;
      step = later - earlier;
      check_value(name, int'(step), expect_period(cfg.downsample, cfg.merging) % 4096);
   endtask

   // trigger entry lies at most period + 2 cycles before t + 2
   task automatic check_trigger_index(input logic [11:0] t, input logic [11:0] entry);
      logic [11:0] back;
      int          limit;
      limit = expect_period(cfg.downsample, cfg.merging) + 2;
      back  = t + 12'd2 - entry;
      if (int'(back) > limit) begin
         $display("MISMATCH at %0t: trigger entry index got %0d expected %0d down to %0d",
                  $time, entry, 12'(t + 12'd2), 12'(t + 12'd2 - 12'(limit)));
         mismatches++;
         errors++;
      end
   endtask

   task automatic report();
      $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
   endtask

   always @(negedge clklvds) begin
      logic fire_seen;
      logic exp_b;
      if (!rst_n) begin
         prev_state  = scope_pkg::acq_idle;
         prev_fwd_in = 1'b0;
         prev_out    = 1'b0;
      end else begin
         // a wait state left for post means the trigger fired
         fire_seen = (prev_state == scope_pkg::acq_fire || prev_state == scope_pkg::acq_lvds
                      || prev_state == scope_pkg::acq_auto)
                     && status.state == scope_pkg::acq_post;
         exp_b = fire_seen && !(prev_state == scope_pkg::acq_lvds && prev_fwd_in);
         check_value("lvds_trig_out", int'(lvds_trig_out), int'(fire_seen));
         check_value("lvds_trig_out_b", int'(lvds_trig_out_b), int'(exp_b));
         if (prev_out && (lvds_trig_out || lvds_trig_out_b))
            fail("trigger output stayed high for more than one cycle");
         check_value("busy", int'(status.busy),
                     int'(status.state != scope_pkg::acq_idle
                          && status.state != scope_pkg::acq_done));
         if (status.state == scope_pkg::acq_done && prev_state != scope_pkg::acq_done)
            exp_events++;
         check_value("event_count", int'(status.event_count), exp_events);
         if (lvds_trig_out) fwd_pulses++;
         if (lvds_trig_out_b) bwd_pulses++;
         prev_state  = status.state;
         prev_fwd_in = lvds_trig_in;
         prev_out    = lvds_trig_out || lvds_trig_out_b;
      end
   end

endmodule

/* testbench/tb_top.sv */
// scope trigger testbench
`timescale 1ns/100ps

module tb_top;

   // test lengths in decimated periods (pre + post + overhead) times period
   localparam int test_cycles = (4 + 8 + 20) * 2 + (3 + 6 + 20) * 12
                              + (4 + 4 + 20) * 4 + (2 + 3 + 20) * 2 + (2 + 2 + 20);
   localparam int timeout_cycles = 3 * test_cycles;

   logic                         clklvds = 1'b0;
   logic                         rst_n;
   scope_pkg::cfg_t              cfg;
   scope_pkg::frame_t            samples = '0;
   logic                         readout_done;
   logic [scope_pkg::addr_w-1:0] rd_addr;
   logic                         lvds_trig_in;
   logic                         lvds_trig_in_b;
   scope_pkg::status_t           status;
   scope_pkg::frame_t            rd_data;
   logic                         lvds_trig_out;
   logic                         lvds_trig_out_b;

   int                 cyc = 0;
   logic               place_valid;
   int                 place_lane;
   scope_pkg::sample_t place_val;
   logic [11:0]        placed_idx = '0;  // index of the last placed frame

   scope_trigger_top dut (.*);

   acq_monitor mon (
      .clklvds         (clklvds),
      .rst_n           (rst_n),
      .cfg             (cfg),
      .status          (status),
      .lvds_trig_in    (lvds_trig_in),
      .lvds_trig_out   (lvds_trig_out),
      .lvds_trig_out_b (lvds_trig_out_b)
   );

   always #10 clklvds = ~clklvds;

   always @(posedge clklvds) begin
      cyc <= cyc + 1;
      if (cyc >= timeout_cycles) begin
         $display("timeout: run did not finish within %0d cycles", timeout_cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   // random frame inside the thresholds, cycle index in sample 39
   always @(posedge clklvds) begin
      scope_pkg::frame_t f;
      for (int i = 0; i < 39; i++)
         f[i] = scope_pkg::sample_t'(int'($urandom_range(1000)) - 500);
      f[39] = scope_pkg::sample_t'(cyc[11:0]);
      if (place_valid) begin
         for (int p = 0; p < scope_pkg::lane_samples; p++)
            f[place_lane * scope_pkg::lane_samples + p] = place_val;
         placed_idx <= cyc[11:0];
      end
      samples <= f;
   end

   task automatic arm(input scope_pkg::trig_kind_t kind, input logic [4:0] ds,
                      input logic [7:0] m, input int pre, input int post,
                      input logic dual, input logic chan);
      @(posedge clklvds);
      cfg <= '{lower_thresh: scope_pkg::sample_t'(-1000),
               upper_thresh: scope_pkg::sample_t'(1000),
               pre_length: 16'(pre), post_length: 16'(post), trig_kind: kind,
               trig_chan: chan, dual_chan: dual, downsample: ds, merging: m, live: 1'b1};
   endtask

   task automatic wait_state(input scope_pkg::acq_state_t s);
      do @(negedge clklvds); while (status.state != s);
   endtask

   task automatic put_frame(input int lane, input int val);
      @(posedge clklvds);
      place_lane  <= lane;
      place_val   <= scope_pkg::sample_t'(val);
      place_valid <= 1'b1;
      @(posedge clklvds);
      place_valid <= 1'b0;
   endtask

   task automatic finish_readout();
      @(posedge clklvds);
      readout_done <= 1'b1;
      cfg.live     <= 1'b0;
      @(posedge clklvds);
      readout_done <= 1'b0;
      wait_state(scope_pkg::acq_idle);
   endtask

   task automatic read_index(input logic [scope_pkg::addr_w-1:0] addr,
                             output logic [11:0] idx);
      @(posedge clklvds);
      rd_addr <= addr;
      @(posedge clklvds);
      @(negedge clklvds);
      idx = rd_data[39];
   endtask

   initial begin
      int                           ev0;
      int                           f0;
      int                           b0;
      logic [scope_pkg::addr_w-1:0] ta;
      logic [11:0]                  prev_idx;
      logic [11:0]                  idx;
      void'($urandom(32'h5a1b_e16c));
      rst_n          = 1'b0;
      cfg            = '0;
      readout_done   = 1'b0;
      rd_addr        = '0;
      lvds_trig_in   = 1'b0;
      lvds_trig_in_b = 1'b0;
      place_valid    = 1'b0;
      place_lane     = 0;
      place_val      = '0;
      repeat (5) @(posedge clklvds);
      rst_n <= 1'b1;
      @(negedge clklvds);

      // reset values
      mon.check_value("busy", int'(status.busy), 0);
      mon.check_value("lvds_trig_out", int'(lvds_trig_out), 0);
      mon.check_value("lvds_trig_out_b", int'(lvds_trig_out_b), 0);
      mon.check_value("event_count", int'(status.event_count), 0);

      // auto trigger
      ev0 = int'(status.event_count);
      f0  = mon.fwd_pulses;
      b0  = mon.bwd_pulses;
      arm(scope_pkg::trig_auto, 5'd1, 8'd0, 4, 8, 1'b0, 1'b0);
      wait_state(scope_pkg::acq_done);
      mon.check_value("event_count", int'(status.event_count), ev0 + 1);
      mon.check_value("forward pulses", mon.fwd_pulses, f0 + 1);
      mon.check_value("backward pulses", mon.bwd_pulses, b0 + 1);
      finish_readout();
      repeat (2) @(negedge clklvds);
      mon.check_value("state", int'(status.state), int'(scope_pkg::acq_idle));

      // decimation spacing in the buffer
      arm(scope_pkg::trig_auto, 5'd2, 8'd3, 3, 6, 1'b0, 1'b0);
      wait_state(scope_pkg::acq_done);
      ta = status.trig_address;
      read_index(ta, prev_idx);
      for (int k = 1; k < 6; k++) begin
         read_index(ta + scope_pkg::addr_w'(k), idx);
         mon.check_spacing("stored cycle index step", prev_idx, idx);
         prev_idx = idx;
      end
      finish_readout();

      // rising edge, channel 0 of two
      arm(scope_pkg::trig_rise, 5'd1, 8'd2, 4, 4, 1'b1, 1'b0);
      wait_state(scope_pkg::acq_armed);
      put_frame(0, 1500);  // high without a low first
      repeat (4) @(negedge clklvds);
      mon.check_value("state", int'(status.state), int'(scope_pkg::acq_armed));
      put_frame(2, -1500);
      wait_state(scope_pkg::acq_fire);
      put_frame(0, 1500);
      wait_state(scope_pkg::acq_done);
      read_index(status.trig_address, idx);
      mon.check_trigger_index(placed_idx, idx);
      finish_readout();

      // lvds trigger from the forward line
      arm(scope_pkg::trig_lvds, 5'd0, 8'd0, 2, 3, 1'b0, 1'b0);
      wait_state(scope_pkg::acq_lvds);
      f0 = mon.fwd_pulses;
      b0 = mon.bwd_pulses;
      @(posedge clklvds);
      lvds_trig_in <= 1'b1;
      @(posedge clklvds);
      lvds_trig_in <= 1'b0;
      wait_state(scope_pkg::acq_done);
      mon.check_value("forward pulses", mon.fwd_pulses, f0 + 1);
      mon.check_value("backward pulses", mon.bwd_pulses, b0);
      finish_readout();

      // kind change while waiting
      ev0 = int'(status.event_count);
      arm(scope_pkg::trig_lvds, 5'd0, 8'd0, 2, 3, 1'b0, 1'b0);
      wait_state(scope_pkg::acq_lvds);
      @(posedge clklvds);
      cfg.trig_kind <= scope_pkg::trig_off;
      cfg.live      <= 1'b0;
      wait_state(scope_pkg::acq_idle);
      repeat (4) @(negedge clklvds);
      mon.check_value("state", int'(status.state), int'(scope_pkg::acq_idle));
      mon.check_value("event_count", int'(status.event_count), ev0);

      // falling edge, crossings on the other channel are ignored
      arm(scope_pkg::trig_fall, 5'd0, 8'd1, 2, 2, 1'b1, 1'b0);
      wait_state(scope_pkg::acq_armed);
      put_frame(1, 1500);
      put_frame(1, -1500);
      repeat (4) @(negedge clklvds);
      mon.check_value("state", int'(status.state), int'(scope_pkg::acq_armed));
      ev0 = int'(status.event_count);
      put_frame(2, 1500);
      wait_state(scope_pkg::acq_fire);
      put_frame(0, -1500);
      wait_state(scope_pkg::acq_done);
      mon.check_value("event_count", int'(status.event_count), ev0 + 1);
      finish_readout();

      repeat (3) @(negedge clklvds);
      mon.report();
      if (mon.errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* scope_trigger.f */
src/scope_pkg.sv
src/sample_decimator.sv
src/edge_detector.sv
src/wave_buffer.sv
src/acq_fsm.sv
src/scope_trigger_top.sv
testbench/acq_monitor.sv
testbench/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -j 0
TOP       := tb_top
FILELIST  := scope_trigger.f

BIN  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '=== PASS ==='

clean:
	rm -rf obj_dir
